// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= periph_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || exit 1

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== apb_splitter.sv ====
// APB address decoder, routes each access to the timer or the UART
// and answers unmapped addresses with an error response
module apb_splitter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  periph_pkg::apb_req_t i_apb,
    output periph_pkg::apb_rsp_t o_apb,
    output periph_pkg::apb_req_t o_timer_req,
    input  periph_pkg::data_t    i_timer_prdata,
    input  logic                 i_timer_pslverr,
    output periph_pkg::apb_req_t o_uart_req,
    input  periph_pkg::apb_rsp_t i_uart_rsp
);

    logic [periph_pkg::SLV_SEL_MSB-periph_pkg::SLV_SEL_LSB:0] sel;
    logic timer_hit;
    logic uart_hit;

    assign sel       = i_apb.paddr[periph_pkg::SLV_SEL_MSB:periph_pkg::SLV_SEL_LSB];
    assign timer_hit = (sel == periph_pkg::SEL_TIMER);
    assign uart_hit  = (sel == periph_pkg::SEL_UART);

    // ------------------------------
    // request fan-out, strobes gated per slave
    always_comb begin
        o_timer_req         = i_apb;
        o_timer_req.psel    = i_apb.psel & timer_hit;
        o_timer_req.penable = i_apb.penable & timer_hit;

        o_uart_req          = i_apb;
        o_uart_req.psel     = i_apb.psel & uart_hit;
        o_uart_req.penable  = i_apb.penable & uart_hit;
    end

    // ------------------------------
    // response mux
    always_comb begin
        if (timer_hit) begin
            // timer is zero-wait
            o_apb.prdata  = i_timer_prdata;
            o_apb.pready  = 1'b1;
            o_apb.pslverr = i_timer_pslverr;
        end else if (uart_hit) begin
            o_apb = i_uart_rsp;
        end else begin
            // unmapped hole
            o_apb.prdata  = '0;
            o_apb.pready  = 1'b1;
            o_apb.pslverr = i_apb.psel;
        end
    end

    // ------------------------------
    // checks
    a_one_hot_psel : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(o_timer_req.psel && o_uart_req.psel)
    );

    // master keeps the address while a slave stalls
    a_addr_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        (i_apb.psel && i_apb.penable && !o_apb.pready) |=> $stable(i_apb.paddr)
    );

endmodule

// ==== filelist.f ====
periph_pkg.sv
apb_splitter.sv
us_tick_gen.sv
riscv_timer.sv
uart_tx_apb.sv
periph_top.sv
periph_tb.sv

// ==== periph_pkg.sv ====
// shared bus types, structs and address map for the peripheral block
// (APB splitter, machine timer, transmit-only UART)
package periph_pkg;

    // ------------------------------
    // bus and payload widths
    typedef logic [15:0] paddr_t;
    typedef logic [31:0] data_t;
    typedef logic [63:0] mtime_t;
    typedef logic [7:0]  uart_byte_t;

    typedef struct packed {
        logic   psel;
        logic   penable;
        logic   pwrite;
        paddr_t paddr;
        data_t  pwdata;
    } apb_req_t;

    typedef struct packed {
        data_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    // ------------------------------
    // slave select in the top address bits
    localparam int SLV_SEL_MSB = 15;
    localparam int SLV_SEL_LSB = 14;

    localparam logic [SLV_SEL_MSB-SLV_SEL_LSB:0] SEL_TIMER = 2'd0;
    localparam logic [SLV_SEL_MSB-SLV_SEL_LSB:0] SEL_UART  = 2'd1;

    // timer registers, hart h compare at CMP_BASE + 8h
    localparam paddr_t TMR_CTRL     = 16'h0000;
    localparam paddr_t TMR_MSIP     = 16'h0004;
    localparam paddr_t TMR_MTIME    = 16'h0008;
    localparam paddr_t TMR_MTIMEH   = 16'h000C;
    localparam paddr_t TMR_CMP_BASE = 16'h0010;

    // uart registers
    localparam paddr_t UART_DATA = 16'h4000;
    localparam paddr_t UART_STAT = 16'h4004;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uart_state_t;

endpackage

// ==== periph_tb.sv ====
// testbench for the peripheral block, table-driven APB tests
// with a UART frame decoder running alongside
module periph_tb;

    localparam int CLK_MHZ    = 4;
    localparam int N_HARTS    = 2;
    localparam int BAUD_DIV   = 8;
    localparam int RST_CYCLES = 16;
    localparam int DRV        = 2;

    typedef enum {
        K_WR, K_RD, K_RDERR, K_SAVE, K_SAME, K_MORE,
        K_HALT, K_SIRQ, K_TIRQ, K_WAIT, K_STALL, K_FRAME
    } kind_t;

    logic                 clk;
    logic                 rst_n;
    periph_pkg::apb_req_t apb_req;
    periph_pkg::apb_rsp_t apb_rsp;
    logic                 dbg_halt;
    logic [N_HARTS-1:0]   soft_irq;
    logic [N_HARTS-1:0]   timer_irq;
    logic                 uart_tx;

    // test table, one entry per index
    string                  t_name[$];
    kind_t                  t_kind[$];
    periph_pkg::paddr_t     t_addr[$];
    periph_pkg::data_t      t_data[$];
    periph_pkg::data_t      t_exp[$];
    periph_pkg::uart_byte_t rx_q[$];
    periph_pkg::data_t      saved;
    int                     cycle_cnt = 0;
    int                     cycle_limit;

    periph_top #(
        .CLK_MHZ  (CLK_MHZ),
        .N_HARTS  (N_HARTS),
        .BAUD_DIV (BAUD_DIV)
    ) periph_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_apb       (apb_req),
        .o_apb       (apb_rsp),
        .i_dbg_halt  (dbg_halt),
        .o_soft_irq  (soft_irq),
        .o_timer_irq (timer_irq),
        .o_uart_tx   (uart_tx)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopped on timeout");
        end
    end

    // ------------------------------
    // compare tasks
    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input periph_pkg::data_t exp,
                              input periph_pkg::data_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_irq(input string name, input logic [N_HARTS-1:0] exp,
                             input logic [N_HARTS-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_byte(input string name, input periph_pkg::uart_byte_t exp,
                              input periph_pkg::uart_byte_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
            stop_run();
        end
    endtask

    // ------------------------------
    // APB master, setup then access until pready
    task automatic apb_xfer(input periph_pkg::paddr_t addr, input logic wr,
                            input periph_pkg::data_t wdata, output periph_pkg::data_t rdata,
                            output logic err, output int waits);
        waits = 0;
        @(posedge clk);
        #DRV;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #DRV;
        apb_req.penable = 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready) begin
            waits++;
            @(negedge clk);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #DRV;
        apb_req = '0;
    endtask

    // mid-bit sampling of each 8N1 frame, bytes go to rx_q
    initial begin : frame_decoder
        periph_pkg::uart_byte_t rx;
        @(posedge rst_n);
        forever begin
            @(negedge uart_tx);
            repeat (BAUD_DIV / 2) @(negedge clk);
            check_flag("start bit", 1'b0, uart_tx);
            for (int b = 0; b < 8; b++) begin
                repeat (BAUD_DIV) @(negedge clk);
                rx[b] = uart_tx;
            end
            repeat (BAUD_DIV) @(negedge clk);
            check_flag("stop bit", 1'b1, uart_tx);
            // let the stop bit end so busy has dropped
            repeat (BAUD_DIV / 2 + 1) @(negedge clk);
            rx_q.push_back(rx);
        end
    end

    task automatic add_test(input string name, input kind_t kind, input periph_pkg::paddr_t addr,
                            input periph_pkg::data_t data, input periph_pkg::data_t exp);
        t_name.push_back(name);
        t_kind.push_back(kind);
        t_addr.push_back(addr);
        t_data.push_back(data);
        t_exp.push_back(exp);
    endtask

    // ------------------------------
    // stimulus and expected values
    task automatic build_table();
        add_test("rst msip", K_RD, periph_pkg::TMR_MSIP, 32'h0, 32'h0);
        add_test("rst soft irq", K_SIRQ, 16'h0, 32'h0, 32'h0);
        add_test("rst timer irq", K_TIRQ, 16'h0, 32'h0, 32'h0);
        add_test("rst enable", K_RD, periph_pkg::TMR_CTRL, 32'h0, 32'h1);
        add_test("rst cmp0 lo", K_RD, 16'h0010, 32'h0, 32'hFFFF_FFFF);
        add_test("rst cmp0 hi", K_RD, 16'h0014, 32'h0, 32'hFFFF_FFFF);
        add_test("rst cmp1 hi", K_RD, 16'h001C, 32'h0, 32'hFFFF_FFFF);
        add_test("unmapped sel 2", K_RDERR, 16'h8000, 32'h0, 32'h0);
        add_test("unmapped sel 3", K_RDERR, 16'hC000, 32'h0, 32'h0);
        add_test("disable", K_WR, periph_pkg::TMR_CTRL, 32'h0, 32'h0);
        add_test("set mtime lo", K_WR, periph_pkg::TMR_MTIME, 32'h0000_1000, 32'h0);
        add_test("set mtime hi", K_WR, periph_pkg::TMR_MTIMEH, 32'h0000_0002, 32'h0);
        add_test("mtime lo back", K_RD, periph_pkg::TMR_MTIME, 32'h0, 32'h0000_1000);
        add_test("mtime hi back", K_RD, periph_pkg::TMR_MTIMEH, 32'h0, 32'h0000_0002);
        add_test("halt on", K_HALT, 16'h0, 32'h1, 32'h0);
        add_test("enable halted", K_WR, periph_pkg::TMR_CTRL, 32'h1, 32'h0);
        add_test("halt read a", K_SAVE, periph_pkg::TMR_MTIME, 32'h0, 32'h0);
        add_test("halt gap", K_WAIT, 16'h0, 32'd40, 32'h0);
        add_test("halt read b", K_SAME, periph_pkg::TMR_MTIME, 32'h0, 32'h0);
        add_test("halt off", K_HALT, 16'h0, 32'h0, 32'h0);
        add_test("count gap", K_WAIT, 16'h0, 32'd20, 32'h0);
        add_test("count read", K_MORE, periph_pkg::TMR_MTIME, 32'h0, 32'h0);
        add_test("freeze", K_WR, periph_pkg::TMR_CTRL, 32'h0, 32'h0);
        add_test("freeze lo", K_WR, periph_pkg::TMR_MTIME, 32'h0000_0100, 32'h0);
        add_test("freeze hi", K_WR, periph_pkg::TMR_MTIMEH, 32'h0, 32'h0);
        add_test("cmp0 hi", K_WR, 16'h0014, 32'h0, 32'h0);
        add_test("cmp0 below", K_WR, 16'h0010, 32'h0000_00FF, 32'h0);
        add_test("irq below", K_TIRQ, 16'h0, 32'h0, 32'h1);
        add_test("cmp0 above", K_WR, 16'h0010, 32'h0000_0101, 32'h0);
        add_test("irq above", K_TIRQ, 16'h0, 32'h0, 32'h0);
        add_test("msip 01", K_WR, periph_pkg::TMR_MSIP, 32'h1, 32'h0);
        add_test("soft irq 01", K_SIRQ, 16'h0, 32'h0, 32'h1);
        add_test("msip 10", K_WR, periph_pkg::TMR_MSIP, 32'h2, 32'h0);
        add_test("soft irq 10", K_SIRQ, 16'h0, 32'h0, 32'h2);
        add_test("msip 11", K_WR, periph_pkg::TMR_MSIP, 32'h3, 32'h0);
        add_test("soft irq 11", K_SIRQ, 16'h0, 32'h0, 32'h3);
        add_test("send 55", K_WR, periph_pkg::UART_DATA, 32'h55, 32'h0);
        add_test("busy 55", K_RD, periph_pkg::UART_STAT, 32'h0, 32'h1);
        add_test("frame 55", K_FRAME, 16'h0, 32'h0, 32'h55);
        add_test("idle 55", K_RD, periph_pkg::UART_STAT, 32'h0, 32'h0);
        add_test("send a3", K_WR, periph_pkg::UART_DATA, 32'hA3, 32'h0);
        add_test("busy a3", K_RD, periph_pkg::UART_STAT, 32'h0, 32'h1);
        add_test("frame a3", K_FRAME, 16'h0, 32'h0, 32'hA3);
        add_test("send 3c", K_WR, periph_pkg::UART_DATA, 32'h3C, 32'h0);
        add_test("send c5 stalled", K_STALL, periph_pkg::UART_DATA, 32'hC5, 32'h0);
        add_test("frame 3c", K_FRAME, 16'h0, 32'h0, 32'h3C);
        add_test("frame c5", K_FRAME, 16'h0, 32'h0, 32'hC5);
        add_test("idle c5", K_RD, periph_pkg::UART_STAT, 32'h0, 32'h0);
    endtask

    task automatic run_test(input int i);
        periph_pkg::data_t rdata;
        logic              err;
        int                waits;
        case (t_kind[i])
            K_WR, K_STALL: begin
                apb_xfer(t_addr[i], 1'b1, t_data[i], rdata, err, waits);
                check_flag(t_name[i], 1'b0, err);
                if (t_kind[i] == K_STALL) begin
                    check_flag({t_name[i], " pready low"}, 1'b1, waits > 0);
                end
            end
            K_RD, K_RDERR, K_SAVE, K_SAME, K_MORE: begin
                apb_xfer(t_addr[i], 1'b0, '0, rdata, err, waits);
                check_flag(t_name[i], t_kind[i] == K_RDERR, err);
                if (t_kind[i] == K_RD || t_kind[i] == K_RDERR) begin
                    check_data(t_name[i], t_exp[i], rdata);
                end else if (t_kind[i] == K_SAVE) begin
                    saved = rdata;
                end else if (t_kind[i] == K_SAME) begin
                    check_data(t_name[i], saved, rdata);
                end else if (rdata <= saved) begin
                    $display("MISMATCH %s: expected above %h, actual %h",
                             t_name[i], saved, rdata);
                    stop_run();
                end
            end
            K_HALT: begin
                @(posedge clk);
                #DRV;
                dbg_halt = t_data[i][0];
            end
            K_WAIT: repeat (t_data[i]) @(posedge clk);
            K_SIRQ: begin
                @(negedge clk);
                check_irq(t_name[i], t_exp[i][N_HARTS-1:0], soft_irq);
            end
            K_TIRQ: begin
                @(negedge clk);
                check_irq(t_name[i], t_exp[i][N_HARTS-1:0], timer_irq);
            end
            default: begin
                while (rx_q.size() == 0) @(negedge clk);
                check_byte(t_name[i], t_exp[i][7:0], rx_q.pop_front());
            end
        endcase
    endtask

    initial begin
        rst_n    = 1'b0;
        apb_req  = '0;
        dbg_halt = 1'b0;
        build_table();
        cycle_limit = RST_CYCLES + t_name.size() * (10 * BAUD_DIV + 20);
        repeat (RST_CYCLES) @(posedge clk);
        #DRV;
        rst_n = 1'b1;
        for (int i = 0; i < t_name.size(); i++) begin
            run_test(i);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== periph_top.sv ====
// peripheral block top: APB splitter feeding the machine timer
// and the UART transmitter, plus the microsecond timebase
module periph_top #(
    parameter int CLK_MHZ  = 4,
    parameter int N_HARTS  = 2,
    parameter int BAUD_DIV = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  periph_pkg::apb_req_t i_apb,
    output periph_pkg::apb_rsp_t o_apb,
    input  logic                 i_dbg_halt,
    output logic [N_HARTS-1:0]   o_soft_irq,
    output logic [N_HARTS-1:0]   o_timer_irq,
    output logic                 o_uart_tx
);

    periph_pkg::apb_req_t timer_req;
    periph_pkg::data_t    timer_prdata;
    logic                 timer_pslverr;
    periph_pkg::apb_req_t uart_req;
    periph_pkg::apb_rsp_t uart_rsp;
    logic                 tick;

    // ------------------------------
    // bus fabric
    apb_splitter apb_splitter_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_apb           (i_apb),
        .o_apb           (o_apb),
        .o_timer_req     (timer_req),
        .i_timer_prdata  (timer_prdata),
        .i_timer_pslverr (timer_pslverr),
        .o_uart_req      (uart_req),
        .i_uart_rsp      (uart_rsp)
    );

    // ------------------------------
    // timer and its timebase
    us_tick_gen #(
        .CLK_MHZ (CLK_MHZ)
    ) us_tick_gen_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .o_tick (tick)
    );

    riscv_timer #(
        .N_HARTS (N_HARTS)
    ) riscv_timer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_req       (timer_req),
        .o_prdata    (timer_prdata),
        .o_pslverr   (timer_pslverr),
        .i_tick      (tick),
        .i_dbg_halt  (i_dbg_halt),
        .o_soft_irq  (o_soft_irq),
        .o_timer_irq (o_timer_irq)
    );

    // serial port
    uart_tx_apb #(
        .BAUD_DIV (BAUD_DIV)
    ) uart_tx_apb_i (
        .clk   (clk),
        .rst_n (rst_n),
        .i_req (uart_req),
        .o_rsp (uart_rsp),
        .o_tx  (o_uart_tx)
    );

endmodule

// ==== riscv_timer.sv ====
// RISC-V machine timer: 64-bit mtime, per-hart mtimecmp and msip,
// with level timer and software interrupts per hart
module riscv_timer #(
    parameter int N_HARTS = 2
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  periph_pkg::apb_req_t i_req,
    output periph_pkg::data_t    o_prdata,
    output logic                 o_pslverr,
    input  logic                 i_tick,
    input  logic                 i_dbg_halt,
    output logic [N_HARTS-1:0]   o_soft_irq,
    output logic [N_HARTS-1:0]   o_timer_irq
);

    localparam int HW = (N_HARTS > 1) ? $clog2(N_HARTS) : 1;

    logic                en;
    logic [N_HARTS-1:0]  msip;
    periph_pkg::mtime_t  mtime;
    periph_pkg::mtime_t  mtimecmp [N_HARTS];

    periph_pkg::paddr_t  cmp_off;
    logic                cmp_hit;
    logic [HW-1:0]       cmp_idx;
    logic                reg_hit;
    logic                wr_en;
    logic                count_en;

    // ------------------------------
    // address decode
    assign wr_en    = i_req.psel & i_req.penable & i_req.pwrite;
    assign count_en = i_tick & en & ~i_dbg_halt;

    assign cmp_off = i_req.paddr - periph_pkg::TMR_CMP_BASE;
    assign cmp_hit = (i_req.paddr >= periph_pkg::TMR_CMP_BASE)
                  && (cmp_off < periph_pkg::paddr_t'(8 * N_HARTS))
                  && (i_req.paddr[1:0] == 2'b00);
    // 8 bytes per hart, bit 2 picks the high word
    assign cmp_idx = cmp_off[3 +: HW];

    always_comb begin
        o_prdata = '0;
        reg_hit  = 1'b1;
        case (i_req.paddr)
            periph_pkg::TMR_CTRL:   o_prdata = periph_pkg::data_t'(en);
            periph_pkg::TMR_MSIP:   o_prdata = periph_pkg::data_t'(msip);
            periph_pkg::TMR_MTIME:  o_prdata = mtime[31:0];
            periph_pkg::TMR_MTIMEH: o_prdata = mtime[63:32];
            default: begin
                reg_hit = cmp_hit;
                for (int h = 0; h < N_HARTS; h++) begin
                    if (cmp_hit && cmp_idx == HW'(h)) begin
                        o_prdata = cmp_off[2] ? mtimecmp[h][63:32] : mtimecmp[h][31:0];
                    end
                end
            end
        endcase
    end

    assign o_pslverr = i_req.psel & ~reg_hit;

    // ------------------------------
    // control, msip and the counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en    <= 1'b1;
            msip  <= '0;
            mtime <= '0;
        end else begin
            if (wr_en && i_req.paddr == periph_pkg::TMR_CTRL) begin
                en <= i_req.pwdata[0];
            end
            if (wr_en && i_req.paddr == periph_pkg::TMR_MSIP) begin
                msip <= i_req.pwdata[N_HARTS-1:0];
            end
            // a bus write wins over the tick
            if (wr_en && i_req.paddr == periph_pkg::TMR_MTIME) begin
                mtime <= {mtime[63:32], i_req.pwdata};
            end else if (wr_en && i_req.paddr == periph_pkg::TMR_MTIMEH) begin
                mtime <= {i_req.pwdata, mtime[31:0]};
            end else if (count_en) begin
                mtime <= mtime + 1'b1;
            end
        end
    end

    assign o_soft_irq = msip;

    // ------------------------------
    // per-hart compare
    for (genvar h = 0; h < N_HARTS; h++) begin : g_hart
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                // all ones keeps mtip low out of reset
                mtimecmp[h] <= '1;
            end else if (wr_en && cmp_hit && cmp_idx == HW'(h)) begin
                if (cmp_off[2]) begin
                    mtimecmp[h][63:32] <= i_req.pwdata;
                end else begin
                    mtimecmp[h][31:0] <= i_req.pwdata;
                end
            end
        end

        assign o_timer_irq[h] = (mtime >= mtimecmp[h]);
    end

    // the splitter gates both strobes together
    a_penable_needs_psel : assert property (
        @(posedge clk) disable iff (!rst_n)
        i_req.penable |-> i_req.psel
    );

endmodule

// ==== uart_tx_apb.sv ====
// APB-mapped 8N1 serial transmitter with busy status and
// write back-pressure while a frame is in flight
module uart_tx_apb #(
    parameter int BAUD_DIV = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  periph_pkg::apb_req_t i_req,
    output periph_pkg::apb_rsp_t o_rsp,
    output logic                 o_tx
);

    localparam int BW = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

    periph_pkg::uart_state_t state;
    logic [BW-1:0]           baud_cnt;
    logic [2:0]              bit_idx;
    periph_pkg::uart_byte_t  shreg;

    logic busy;
    logic data_wr;
    logic stat_rd;
    logic accept;
    logic bit_end;

    // ------------------------------
    // bus side
    assign busy    = (state != periph_pkg::IDLE);
    assign data_wr = i_req.pwrite && (i_req.paddr == periph_pkg::UART_DATA);
    assign stat_rd = !i_req.pwrite && (i_req.paddr == periph_pkg::UART_STAT);
    assign accept  = i_req.psel && i_req.penable && data_wr && !busy;

    always_comb begin
        o_rsp.prdata  = stat_rd ? periph_pkg::data_t'(busy) : '0;
        // stall a data write until the stop bit is done
        o_rsp.pready  = !(data_wr && busy);
        o_rsp.pslverr = i_req.psel && !data_wr && !stat_rd;
    end

    // ------------------------------
    // frame FSM
    assign bit_end = (baud_cnt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= periph_pkg::IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            o_tx     <= 1'b1;
        end else begin
            if (state != periph_pkg::IDLE) begin
                baud_cnt <= bit_end ? BW'(BAUD_DIV - 1) : baud_cnt - 1'b1;
            end
            case (state)
                periph_pkg::IDLE: begin
                    if (accept) begin
                        state    <= periph_pkg::START;
                        baud_cnt <= BW'(BAUD_DIV - 1);
                        o_tx     <= 1'b0;
                    end
                end
                periph_pkg::START: begin
                    if (bit_end) begin
                        state   <= periph_pkg::DATA;
                        bit_idx <= '0;
                        o_tx    <= shreg[0];
                    end
                end
                periph_pkg::DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= periph_pkg::STOP;
                            o_tx  <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            o_tx    <= shreg[1];
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= periph_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    // lsb first, so shift right after every data bit
    always_ff @(posedge clk) begin
        if (accept) begin
            shreg <= i_req.pwdata[7:0];
        end else if (state == periph_pkg::DATA && bit_end) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

    a_idle_line_high : assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == periph_pkg::IDLE) |-> o_tx
    );

endmodule

// ==== us_tick_gen.sv ====
// microsecond timebase, one-cycle tick every CLK_MHZ clocks
module us_tick_gen #(
    parameter int CLK_MHZ = 4
) (
    input  logic clk,
    input  logic rst_n,
    output logic o_tick
);

    // keep at least one bit for a 1 MHz clock
    localparam int CW = (CLK_MHZ > 1) ? $clog2(CLK_MHZ) : 1;

    logic [CW-1:0] tick_ctr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_ctr <= '0;
            o_tick   <= 1'b0;
        end else begin
            if (tick_ctr != '0) begin
                tick_ctr <= tick_ctr - 1'b1;
            end else begin
                tick_ctr <= CW'(CLK_MHZ - 1);
            end
            // pulse on each wrap
            o_tick <= (tick_ctr == '0);
        end
    end

endmodule
